/* logic/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and address width
`define CORE_XLEN 32

// architectural register count, x0 included
`define CORE_REG_COUNT 32

// first fetch address once reset is released
`define CORE_RESET_PC 32'h0000_0000

`endif

/* logic/core_pkg.sv */
package core_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_RTYPE  = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_CLASS_ADD   = 2'b00,    // address arithmetic
        ALU_CLASS_SUB   = 2'b01,    // compare for beq
        ALU_CLASS_FUNCT = 2'b10,    // taken from funct3/funct7
        ALU_CLASS_PASS  = 2'b11     // immediate straight through
    } alu_class_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'b000,
        ALU_SUB    = 3'b001,
        ALU_AND    = 3'b010,
        ALU_OR     = 3'b011,
        ALU_SLT    = 3'b101,
        ALU_PASS_B = 3'b110
    } alu_ctrl_e;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } imm_src_e;

    typedef enum logic [1:0] {
        RES_ALU   = 2'b00,
        RES_MEM   = 2'b01,
        RES_PC4   = 2'b10     // link value
    } result_src_e;

    typedef enum logic [1:0] {
        PC_SEL_PLUS4  = 2'b00,
        PC_SEL_TARGET = 2'b01,  // pc + imm
        PC_SEL_ALU    = 2'b10   // jalr target with bit 0 cleared
    } pc_sel_e;

endpackage

/* logic/main_decoder.sv */
`timescale 1ns/1ps

module main_decoder (
    input  core_pkg::opcode_e     op_i,
    input  logic                  zero_i,
    output core_pkg::result_src_e result_src_o,
    output logic                  mem_write_o,
    output logic                  alu_src_o,
    output logic                  reg_write_o,
    output core_pkg::imm_src_e    imm_src_o,
    output core_pkg::alu_class_e  alu_class_o,
    output core_pkg::pc_sel_e     pc_sel_o
);

    always_comb begin
        // inactive set for unknown opcodes too
        reg_write_o  = 1'b0;
        mem_write_o  = 1'b0;
        alu_src_o    = 1'b0;
        imm_src_o    = core_pkg::IMM_I;
        result_src_o = core_pkg::RES_ALU;
        alu_class_o  = core_pkg::ALU_CLASS_ADD;
        pc_sel_o     = core_pkg::PC_SEL_PLUS4;

        case (op_i)
            core_pkg::OP_LOAD: begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;            // base + offset
                result_src_o = core_pkg::RES_MEM;
            end
            core_pkg::OP_STORE: begin
                mem_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = core_pkg::IMM_S;
            end
            core_pkg::OP_RTYPE: begin
                reg_write_o = 1'b1;
                alu_class_o = core_pkg::ALU_CLASS_FUNCT;
            end
            core_pkg::OP_BRANCH: begin
                imm_src_o   = core_pkg::IMM_B;
                alu_class_o = core_pkg::ALU_CLASS_SUB;  // rs1 - rs2 sets zero
                if (zero_i) begin
                    pc_sel_o = core_pkg::PC_SEL_TARGET;
                end
            end
            core_pkg::OP_LUI: begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = core_pkg::IMM_U;
                alu_class_o = core_pkg::ALU_CLASS_PASS;
            end
            core_pkg::OP_JAL: begin
                reg_write_o  = 1'b1;
                imm_src_o    = core_pkg::IMM_J;
                result_src_o = core_pkg::RES_PC4;  // link into rd
                pc_sel_o     = core_pkg::PC_SEL_TARGET;
            end
            core_pkg::OP_JALR: begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;            // rs1 + I-imm gives target
                result_src_o = core_pkg::RES_PC4;
                pc_sel_o     = core_pkg::PC_SEL_ALU;
            end
            default: begin
                reg_write_o = 1'b0;             // keep defaults
            end
        endcase
    end

endmodule

/* logic/alu_decoder.sv */
`timescale 1ns/1ps

module alu_decoder (
    input  core_pkg::alu_class_e alu_class_i,
    input  logic [2:0]           funct3_i,
    input  logic                 funct7_b5_i,
    input  logic                 op_b5_i,
    output core_pkg::alu_ctrl_e  alu_ctrl_o
);

    logic is_sub;

    // only the register form can encode sub
    assign is_sub = op_b5_i & funct7_b5_i;

    always_comb begin
        case (alu_class_i)
            core_pkg::ALU_CLASS_ADD:  alu_ctrl_o = core_pkg::ALU_ADD;
            core_pkg::ALU_CLASS_SUB:  alu_ctrl_o = core_pkg::ALU_SUB;
            core_pkg::ALU_CLASS_PASS: alu_ctrl_o = core_pkg::ALU_PASS_B;
            default: begin
                case (funct3_i)
                    3'b000:  alu_ctrl_o = is_sub ? core_pkg::ALU_SUB
                                                 : core_pkg::ALU_ADD;
                    3'b010:  alu_ctrl_o = core_pkg::ALU_SLT;
                    3'b110:  alu_ctrl_o = core_pkg::ALU_OR;
                    3'b111:  alu_ctrl_o = core_pkg::ALU_AND;
                    default: alu_ctrl_o = core_pkg::ALU_ADD;   // unsupported funct3
                endcase
            end
        endcase
    end

endmodule

/* logic/imm_extender.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module imm_extender (
    input  logic [31:7]           instr_i,
    input  core_pkg::imm_src_e    imm_src_i,
    output logic [`CORE_XLEN-1:0] imm_ext_o
);

    logic sign;

    assign sign = instr_i[31];  // immediate sign is always bit 31

    always_comb begin
        case (imm_src_i)
            core_pkg::IMM_I:
                imm_ext_o = {{(`CORE_XLEN-12){sign}}, instr_i[31:20]};
            core_pkg::IMM_S:
                imm_ext_o = {{(`CORE_XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            core_pkg::IMM_B:
                imm_ext_o = {{(`CORE_XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                             instr_i[11:8], 1'b0};
            core_pkg::IMM_J:
                imm_ext_o = {{(`CORE_XLEN-20){sign}}, instr_i[19:12], instr_i[20],
                             instr_i[30:21], 1'b0};
            core_pkg::IMM_U:
                imm_ext_o = {instr_i[31:12], 12'b0};   // upper 20 bits
            default:
                imm_ext_o = '0;
        endcase
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module reg_file (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [4:0]            rs1_i,
    input  logic [4:0]            rs2_i,
    input  logic [4:0]            rd_i,
    input  logic                  we_i,
    input  logic [`CORE_XLEN-1:0] wd_i,
    output logic [`CORE_XLEN-1:0] rd1_o,
    output logic [`CORE_XLEN-1:0] rd2_o
);

    logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != 5'd0)) begin   // x0 never written
            regs[rd_i] <= wd_i;
        end
    end

    // combinational read ports
    assign rd1_o = regs[rs1_i];
    assign rd2_o = regs[rs2_i];

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module alu (
    input  logic [`CORE_XLEN-1:0] a_i,
    input  logic [`CORE_XLEN-1:0] b_i,
    input  core_pkg::alu_ctrl_e   ctrl_i,
    output logic [`CORE_XLEN-1:0] y_o,
    output logic                  zero_o
);

    logic [`CORE_XLEN-1:0] sum;
    logic [`CORE_XLEN-1:0] diff;
    logic                  lt;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;
    assign lt   = $signed(a_i) < $signed(b_i);  // signed compare

    always_comb begin
        case (ctrl_i)
            core_pkg::ALU_ADD:    y_o = sum;
            core_pkg::ALU_SUB:    y_o = diff;
            core_pkg::ALU_AND:    y_o = a_i & b_i;
            core_pkg::ALU_OR:     y_o = a_i | b_i;
            core_pkg::ALU_SLT:    y_o = {{(`CORE_XLEN-1){1'b0}}, lt};
            core_pkg::ALU_PASS_B: y_o = b_i;    // lui
            default:              y_o = sum;
        endcase
    end

    assign zero_o = (y_o == '0);

endmodule

/* logic/single_cycle_core.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module single_cycle_core (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [31:0]           instr_i,
    input  logic [`CORE_XLEN-1:0] data_rdata_i,
    output logic [`CORE_XLEN-1:0] pc_o,
    output logic [`CORE_XLEN-1:0] data_addr_o,
    output logic [`CORE_XLEN-1:0] data_wdata_o,
    output logic                  data_we_o
);

    logic [`CORE_XLEN-1:0] pc_q;
    logic [`CORE_XLEN-1:0] pc_next;
    logic [`CORE_XLEN-1:0] pc_plus4;
    logic [`CORE_XLEN-1:0] pc_target;

    core_pkg::result_src_e result_src;
    core_pkg::imm_src_e    imm_src;
    core_pkg::alu_class_e  alu_class;
    core_pkg::alu_ctrl_e   alu_ctrl;
    core_pkg::pc_sel_e     pc_sel;
    logic                  mem_write;
    logic                  alu_src;
    logic                  reg_write;
    logic                  zero;

    logic [`CORE_XLEN-1:0] imm_ext;
    logic [`CORE_XLEN-1:0] rd1;
    logic [`CORE_XLEN-1:0] rd2;
    logic [`CORE_XLEN-1:0] alu_b;
    logic [`CORE_XLEN-1:0] alu_y;
    logic [`CORE_XLEN-1:0] result;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `CORE_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_plus4  = pc_q + `CORE_XLEN'd4;
    assign pc_target = pc_q + imm_ext;   // branch and jal target

    always_comb begin
        case (pc_sel)
            core_pkg::PC_SEL_TARGET: pc_next = pc_target;
            core_pkg::PC_SEL_ALU:    pc_next = {alu_y[`CORE_XLEN-1:1], 1'b0};
            default:                 pc_next = pc_plus4;
        endcase
    end

    main_decoder u_main_decoder (
        .op_i         (core_pkg::opcode_e'(instr_i[6:0])),
        .zero_i       (zero),
        .result_src_o (result_src),
        .mem_write_o  (mem_write),
        .alu_src_o    (alu_src),
        .reg_write_o  (reg_write),
        .imm_src_o    (imm_src),
        .alu_class_o  (alu_class),
        .pc_sel_o     (pc_sel)
    );

    alu_decoder u_alu_decoder (
        .alu_class_i (alu_class),
        .funct3_i    (instr_i[14:12]),
        .funct7_b5_i (instr_i[30]),
        .op_b5_i     (instr_i[5]),
        .alu_ctrl_o  (alu_ctrl)
    );

    imm_extender u_imm_extender (
        .instr_i   (instr_i[31:7]),
        .imm_src_i (imm_src),
        .imm_ext_o (imm_ext)
    );

    reg_file u_reg_file (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rs1_i   (instr_i[19:15]),
        .rs2_i   (instr_i[24:20]),
        .rd_i    (instr_i[11:7]),
        .we_i    (reg_write),
        .wd_i    (result),
        .rd1_o   (rd1),
        .rd2_o   (rd2)
    );

    assign alu_b = alu_src ? imm_ext : rd2;  // immediate or rs2

    alu u_alu (
        .a_i    (rd1),
        .b_i    (alu_b),
        .ctrl_i (alu_ctrl),
        .y_o    (alu_y),
        .zero_o (zero)
    );

    // write-back select
    always_comb begin
        case (result_src)
            core_pkg::RES_MEM: result = data_rdata_i;
            core_pkg::RES_PC4: result = pc_plus4;
            default:           result = alu_y;
        endcase
    end

    assign pc_o         = pc_q;
    assign data_addr_o  = alu_y;
    assign data_wdata_o = rd2;
    assign data_we_o    = mem_write;

endmodule

/* tests/core_sva.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module core_sva (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic [`CORE_XLEN-1:0] pc_i,
    input logic [31:0]           instr_i,
    input logic [`CORE_XLEN-1:0] rd1_i,
    input logic [`CORE_XLEN-1:0] rd2_i,
    input logic                  data_we_i
);

    pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i) pc_i[1:0] == 2'b00)
        else $error("pc is not word aligned");

    // x0 reads back zero on both ports
    x0_rs1_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (instr_i[19:15] == 5'd0) |-> (rd1_i == '0))
        else $error("x0 read on port 1 is not zero");

    x0_rs2_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (instr_i[24:20] == 5'd0) |-> (rd2_i == '0))
        else $error("x0 read on port 2 is not zero");

    no_store_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !data_we_i)
        else $error("store enable high during reset");

endmodule

bind single_cycle_core core_sva u_core_sva (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .pc_i      (pc_o),
    .instr_i   (instr_i),
    .rd1_i     (rd1),
    .rd2_i     (rd2),
    .data_we_i (data_we_o)
);

/* tests/core_tb.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module core_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int R_ITER       = 12;
    localparam int LS_ITER      = 12;
    localparam int BEQ_ITER     = 10;
    localparam int JMP_ITER     = 10;
    // worst-case instruction count over all tests
    localparam int MAX_INSTR    = 1 + R_ITER * 4 + LS_ITER * 2 + BEQ_ITER * 7 + JMP_ITER * 11;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + MAX_INSTR + 50) * CLK_PERIOD;

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_RTYPE = 7'b0110011;
    localparam logic [6:0] OPC_BEQ   = 7'b1100011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [31:0]           instr;
    logic [`CORE_XLEN-1:0] data_rdata;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] data_addr;
    logic [`CORE_XLEN-1:0] data_wdata;
    logic                  data_we;

    logic [31:0] imem [4096];
    logic [31:0] dmem [256];
    logic [31:0] mmem [256];            // model data memory
    logic [31:0] mregs [`CORE_REG_COUNT];
    logic [31:0] mpc;
    int          emit_idx;
    int          errors = 0;
    int          checks = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    single_cycle_core u_single_cycle_core (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .instr_i      (instr),
        .data_rdata_i (data_rdata),
        .pc_o         (pc),
        .data_addr_o  (data_addr),
        .data_wdata_o (data_wdata),
        .data_we_o    (data_we)
    );

    // zero-latency memories
    assign instr      = imem[pc[13:2]];
    assign data_rdata = dmem[data_addr[9:2]];

    always @(posedge clk) begin
        if (rst_n && data_we) begin
            dmem[data_addr[9:2]] <= data_wdata;
        end
    end

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_RTYPE};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, (op == OPC_LOAD) ? 3'b010 : 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OPC_STORE};   // base x0
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BEQ};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [4:0] rand_reg(input int lo);
        return 5'($urandom_range(31, lo));
    endfunction

    function automatic logic [11:0] rand_off();
        return 12'($urandom_range(255, 0) * 4);    // word aligned inside dmem
    endfunction

    function automatic logic [31:0] filler();
        return enc_r(7'd0, rand_reg(0), rand_reg(0), 3'b000, rand_reg(1));
    endfunction

    // ISA reference result of the R-type operations
    function automatic logic [31:0] r_result(input logic [2:0] f3, input logic f7_b5,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return f7_b5 ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    // compare outputs with the model and step it by one instruction
    task automatic run_cycle();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] wb;
        logic [31:0] next_pc;
        logic        wr;
        @(negedge clk);
        ins     = imem[mpc[13:2]];
        a       = mregs[ins[19:15]];
        b       = mregs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        wr      = 1'b0;
        wb      = '0;
        next_pc = mpc + 32'd4;
        compare(pc, mpc, "pc");
        compare(32'(data_we), 32'(ins[6:0] == OPC_STORE), "store enable");
        case (ins[6:0])
            OPC_LOAD: begin
                wr = 1'b1;
                wb = mmem[(a + imm_i) >> 2 & 32'hff];
            end
            OPC_STORE: begin
                compare(data_addr, a + imm_s, "store address");
                compare(data_wdata, b, "store data");
                mmem[(a + imm_s) >> 2 & 32'hff] = b;
            end
            OPC_RTYPE: begin
                wr = 1'b1;
                wb = r_result(ins[14:12], ins[30], a, b);
            end
            OPC_BEQ: begin
                if (a == b) begin
                    next_pc = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OPC_LUI: begin
                wr = 1'b1;
                wb = {ins[31:12], 12'h000};
            end
            OPC_JAL: begin
                wr      = 1'b1;
                wb      = mpc + 32'd4;
                next_pc = mpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_JALR: begin
                wr      = 1'b1;
                wb      = mpc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            default: begin
                wr = 1'b0;      // treated as a no-op
            end
        endcase
        if (wr && (ins[11:7] != 5'd0)) begin
            mregs[ins[11:7]] = wb;
        end
        mpc = next_pc;
    endtask

    // program words land at the edge where the core fetches them
    task automatic begin_program();
        @(posedge clk);
        emit_idx = int'(mpc[13:2]);
    endtask

    task automatic place(input logic [31:0] word);
        imem[emit_idx] <= word;
        emit_idx++;
    endtask

    task automatic run_to_end();
        while (int'(mpc[13:2]) != emit_idx) begin
            run_cycle();
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("test %s done, %0d mismatches", name, errors - err0);
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        compare(pc, `CORE_RESET_PC, "pc in reset");
        compare(32'(data_we), 32'd0, "store enable in reset");
        @(posedge clk);
        rst_n <= 1'b1;
        run_cycle();                    // instruction 0 right after release
        report_test("reset", err0);
    endtask

    task automatic test_rtype();
        int          err0;
        int          sel;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        err0 = errors;
        begin_program();
        for (int i = 0; i < R_ITER; i++) begin
            ra  = rand_reg(1);
            rb  = rand_reg(1);
            rd  = rand_reg(0);
            sel = $urandom_range(4, 0);
            f7  = (sel == 1) ? 7'b0100000 : 7'b0000000;
            f3  = (sel == 2) ? 3'b111 : (sel == 3) ? 3'b110 : (sel == 4) ? 3'b010 : 3'b000;
            place(enc_i(rand_off(), 5'd0, ra, OPC_LOAD));
            place(enc_i(rand_off(), 5'd0, rb, OPC_LOAD));
            place(enc_r(f7, rb, ra, f3, rd));
            place(enc_s(rand_off(), rd));
        end
        run_to_end();
        report_test("rtype", err0);
    endtask

    task automatic test_load_store();
        int         err0;
        logic [4:0] rd;
        err0 = errors;
        begin_program();
        for (int i = 0; i < LS_ITER; i++) begin
            rd = rand_reg(1);
            place(enc_i(rand_off(), 5'd0, rd, OPC_LOAD));
            place(enc_s(rand_off(), rd));
        end
        run_to_end();
        report_test("load_store", err0);
    endtask

    task automatic test_beq();
        int          err0;
        int          k;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [11:0] off_a;
        logic [11:0] off_b;
        err0 = errors;
        begin_program();
        for (int i = 0; i < BEQ_ITER; i++) begin
            ra    = rand_reg(1);
            rb    = rand_reg(1);
            off_a = rand_off();
            off_b = ($urandom_range(1, 0) == 1) ? off_a : rand_off();   // equal or not
            k     = $urandom_range(4, 2);
            place(enc_i(off_a, 5'd0, ra, OPC_LOAD));
            place(enc_i(off_b, 5'd0, rb, OPC_LOAD));
            place(enc_b(13'(k * 4), rb, ra));
            repeat (k - 1) place(filler());
        end
        run_to_end();
        report_test("beq", err0);
    endtask

    task automatic test_jumps();
        int         err0;
        int         k;
        int         m;
        logic [4:0] ru;
        logic [4:0] rl;
        logic [4:0] rj;
        err0 = errors;
        begin_program();
        for (int i = 0; i < JMP_ITER; i++) begin
            ru = rand_reg(0);
            rl = rand_reg(1);
            rj = rand_reg(0);
            k  = $urandom_range(4, 2);
            m  = $urandom_range(2, 0);
            place({20'($urandom()), ru, OPC_LUI});
            place(enc_s(rand_off(), ru));
            place(enc_j(21'(k * 4), rl));
            repeat (k - 1) place(filler());
            // target lands past m skipped words and odd offsets test bit 0 clearing
            place(enc_i(12'(4 * k + 4 * m + $urandom_range(1, 0)), rl, rj, OPC_JALR));
            repeat (m) place(filler());
            place(enc_s(rand_off(), rl));
            place(enc_s(rand_off(), rj));
        end
        run_to_end();
        report_test("jumps", err0);
    endtask

    initial begin
        void'($urandom(32'head85a95));
        rst_n = 1'b0;
        mpc   = `CORE_RESET_PC;
        for (int i = 0; i < 4096; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = $urandom();
            mmem[i] = dmem[i];
        end
        for (int i = 0; i < `CORE_REG_COUNT; i++) begin
            mregs[i] = '0;
        end
        test_reset();
        test_rtype();
        test_load_store();
        test_beq();
        test_jumps();
        $display("checks %0d, mismatches %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+logic
logic/core_pkg.sv
logic/main_decoder.sv
logic/alu_decoder.sv
logic/imm_extender.sv
logic/reg_file.sv
logic/alu.sv
logic/single_cycle_core.sv
tests/core_sva.sv
tests/core_tb.sv
